// ==== calc_pkg.sv ====
// shared widths, types, state encodings and segment table for the calculator RTL
package calc_pkg;

    localparam int BUTTON_WIDTH = 5;
    localparam int SWITCH_WIDTH = 15;

    // button indices, lowest index has priority
    localparam int BTN_LEFT  = 0;
    localparam int BTN_RIGHT = 1;
    localparam int BTN_UP    = 2;
    localparam int BTN_DOWN  = 3;
    localparam int BTN_MID   = 4;

    // switch indices of the supported operations
    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_MUL = 2;

    typedef logic [BUTTON_WIDTH-1:0] button_t;
    typedef logic [SWITCH_WIDTH-1:0] switch_t;
    typedef logic [3:0]              bcd_t;
    typedef logic [7:0]              seg_t;
    typedef logic [3:0]              ctrl_t;
    typedef logic signed [20:0]      result_t;
    typedef logic [19:0]             mag_t;
    typedef bcd_t [6:0]              bcd_word_t;

    // display codes beyond the decimal digits
    localparam bcd_t CODE_BLANK = 4'd10;
    localparam bcd_t CODE_MINUS = 4'd11;

    typedef struct packed {
        logic sign;
        bcd_t d2;
        bcd_t d1;
        bcd_t d0;
    } operand_t;

    typedef enum logic [1:0] {
        OP_NONE,
        ADD,
        SUB,
        MUL
    } op_t;

    typedef enum logic [2:0] {
        IDLE,
        INPUT_A,
        INPUT_B,
        EXE,
        CONVERT,
        DISPLAY
    } ctrl_state_t;

    typedef enum logic [1:0] {
        CUR_DIGIT0,
        CUR_DIGIT1,
        CUR_DIGIT2,
        CUR_SIGN
    } cursor_t;

    // active low segments, dp in bit 0
    localparam seg_t SEG_TABLE [16] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,
        8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1111,
        8'b0000_0001, 8'b0001_1001, 8'b1111_1111, 8'b1111_1101,
        8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111
    };

endpackage

// ==== button_conditioner.sv ====
// debounces the board buttons and emits one prioritized single-cycle pulse per press
module button_conditioner
    import calc_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 2 ** 16
) (
    input  logic    clk,
    input  logic    arst_n,
    input  button_t board_button,
    output button_t press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [CNT_W-1:0] stable_cnt [BUTTON_WIDTH];
    button_t          level;
    button_t          level_d;
    button_t          rise;
    button_t          press_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < BUTTON_WIDTH; i++) begin
                stable_cnt[i] <= '0;
            end
            level   <= '0;
            level_d <= '0;
            press   <= '0;
        end else begin
            // level follows the input only after it held for the full count
            for (int i = 0; i < BUTTON_WIDTH; i++) begin
                if (board_button[i] == level[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    stable_cnt[i] <= '0;
                    level[i]      <= board_button[i];
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
            level_d <= level;
            press   <= press_next;
        end
    end

    assign rise = level & ~level_d;

    // a held lower button masks every higher one
    always_comb begin
        press_next = '0;
        for (int i = 0; i < BUTTON_WIDTH; i++) begin
            press_next[i] = rise[i] & ~(|(level & button_t'((1 << i) - 1)));
        end
    end

    a_press_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(press));

endmodule

// ==== operand_entry.sv ====
// digit entry for one operand: cursor FSM plus three decimal digits and a sign
module operand_entry
    import calc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  ctrl_state_t state,
    input  logic        entry_clear,
    input  button_t     press,
    output operand_t    entry
);

    cursor_t cursor;
    logic    live;
    logic    step;

    // up wraps 9 to 0, down wraps 0 to 9
    function automatic bcd_t step_digit(bcd_t d, logic up);
        bcd_t nxt;
        if (up) begin
            nxt = (d == bcd_t'(9)) ? bcd_t'(0) : d + bcd_t'(1);
        end else begin
            nxt = (d == bcd_t'(0)) ? bcd_t'(9) : d - bcd_t'(1);
        end
        return nxt;
    endfunction

    assign live = (state == INPUT_A) || (state == INPUT_B);
    assign step = press[BTN_UP] | press[BTN_DOWN];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cursor <= CUR_DIGIT0;
            entry  <= '0;
        end else if (entry_clear) begin
            cursor <= CUR_DIGIT0;
            entry  <= '0;
        end else if (live) begin
            // left walks toward the sign, right back to digit 0
            if (press[BTN_LEFT] && cursor != CUR_SIGN) begin
                cursor <= cursor_t'(cursor + 2'd1);
            end else if (press[BTN_RIGHT] && cursor != CUR_DIGIT0) begin
                cursor <= cursor_t'(cursor - 2'd1);
            end

            if (step) begin
                case (cursor)
                    CUR_DIGIT0: entry.d0 <= step_digit(entry.d0, press[BTN_UP]);
                    CUR_DIGIT1: entry.d1 <= step_digit(entry.d1, press[BTN_UP]);
                    CUR_DIGIT2: entry.d2 <= step_digit(entry.d2, press[BTN_UP]);
                    default:    entry.sign <= ~entry.sign;
                endcase
            end
        end
    end

    a_digit_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        (entry.d0 <= bcd_t'(9)) && (entry.d1 <= bcd_t'(9)) && (entry.d2 <= bcd_t'(9))
    );

endmodule

// ==== calc_control.sv ====
// main sequencing FSM: entry, capture, execute, conversion and display paging
module calc_control
    import calc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  button_t     press,
    input  logic        result_valid,
    input  mag_t        magnitude,
    input  logic        invalid,
    input  logic        conv_done,
    output ctrl_state_t state,
    output logic        entry_clear,
    output logic        capture_a,
    output logic        capture_b,
    output logic        page,
    output logic        exe_done,
    output logic [2:0]  display_stage
);

    ctrl_state_t state_next;
    logic        mid;
    logic        two_pages;
    logic        page_step;

    assign mid = press[BTN_MID];

    // first mid press in display turns the page when there is a second one
    assign page_step = (state == DISPLAY) && mid && !page && two_pages && !invalid;

    always_comb begin
        case (state)
            IDLE:    state_next = INPUT_A;
            INPUT_A: state_next = mid ? INPUT_B : INPUT_A;
            INPUT_B: state_next = mid ? EXE : INPUT_B;
            EXE:     state_next = CONVERT;
            CONVERT: state_next = conv_done ? DISPLAY : CONVERT;
            DISPLAY: state_next = (mid && !page_step) ? INPUT_A : DISPLAY;
            default: state_next = IDLE;
        endcase
    end

    assign capture_a   = (state == INPUT_A) && mid;
    assign capture_b   = (state == INPUT_B) && mid;
    assign entry_clear = (state_next != state) && (state_next inside {INPUT_A, INPUT_B, EXE});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            page      <= 1'b0;
            two_pages <= 1'b0;
        end else begin
            state <= state_next;
            if (page_step) begin
                page <= 1'b1;
            end else if (state_next != DISPLAY) begin
                page <= 1'b0;
            end
            if (result_valid) begin
                two_pages <= (magnitude >= mag_t'(1000));
            end
        end
    end

    assign exe_done      = (state == DISPLAY);
    assign display_stage = {2'b00, page} + 3'd1;

    // the execute unit answers exactly one cycle after the EXE state
    a_result_timing: assert property (
        @(posedge clk) disable iff (!arst_n) result_valid |-> $past(state) == EXE
    );

endmodule

// ==== calc_execute.sv ====
// operand and switch capture, op decode, BCD to binary and single-cycle arithmetic
module calc_execute
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  switch_t  board_switch,
    input  operand_t entry,
    input  logic     capture_a,
    input  logic     capture_b,
    output logic     result_valid,
    output mag_t     magnitude,
    output logic     negative,
    output logic     invalid
);

    operand_t a_q;
    operand_t b_q;
    switch_t  sw_q;
    logic     pending;
    op_t      op;
    result_t  a_val;
    result_t  b_val;
    result_t  result;

    function automatic result_t to_binary(operand_t opnd);
        result_t value;
        value = result_t'(opnd.d2) * 21'sd100 + result_t'(opnd.d1) * 21'sd10
              + result_t'(opnd.d0);
        return opnd.sign ? -value : value;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sw_q         <= '0;
            pending      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (capture_b) begin
                sw_q <= board_switch;
            end
            pending      <= capture_b;
            result_valid <= pending;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_a) begin
            a_q <= entry;
        end
        if (capture_b) begin
            b_q <= entry;
        end
        // -0 operands come out as plain zero here
        if (pending) begin
            negative  <= result[20];
            magnitude <= result[20] ? mag_t'(-result) : mag_t'(result);
        end
    end

    // lowest raised switch picks the op
    always_comb begin
        op = OP_NONE;
        if (sw_q[OP_ADD]) begin
            op = ADD;
        end else if (sw_q[OP_SUB]) begin
            op = SUB;
        end else if (sw_q[OP_MUL]) begin
            op = MUL;
        end
    end

    always_comb begin
        a_val = to_binary(a_q);
        b_val = to_binary(b_q);
        case (op)
            ADD:     result = a_val + b_val;
            SUB:     result = a_val - b_val;
            MUL:     result = a_val * b_val;
            default: result = '0;
        endcase
    end

    assign invalid = (op == OP_NONE);

endmodule

// ==== bin_to_bcd.sv ====
// iterative shift-and-add-3 conversion of the result magnitude into seven BCD digits
module bin_to_bcd
    import calc_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  mag_t      magnitude,
    output bcd_word_t bcd,
    output logic      conv_done
);

    localparam int STEPS = $bits(mag_t);
    localparam int CNT_W = $clog2(STEPS);

    mag_t             shift_q;
    logic [CNT_W-1:0] step_cnt;
    logic             busy;
    logic [27:0]      adjusted;

    // add 3 to every digit of 5 or more before the shift
    always_comb begin
        for (int i = 0; i < 7; i++) begin
            adjusted[4*i +: 4] = (bcd[i] >= bcd_t'(5)) ? bcd[i] + bcd_t'(3) : bcd[i];
        end
    end

    assign conv_done = busy && (step_cnt == CNT_W'(STEPS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            bcd      <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            step_cnt <= '0;
            bcd      <= '0;
        end else if (busy) begin
            bcd      <= {adjusted[26:0], shift_q[STEPS-1]};
            step_cnt <= step_cnt + 1'b1;
            if (conv_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= magnitude;
        end else if (busy) begin
            shift_q <= shift_q << 1;
        end
    end

endmodule

// ==== seven_seg_scan.sv ====
// multiplexed four-digit display driver with paging, blanking and segment decode
module seven_seg_scan
    import calc_pkg::*;
#(
    parameter int SCAN_DIV_BITS = 10
) (
    input  logic        clk,
    input  logic        arst_n,
    input  ctrl_state_t state,
    input  operand_t    entry,
    input  bcd_word_t   bcd,
    input  logic        negative,
    input  logic        invalid,
    input  logic        page,
    output ctrl_t       digit_ctrl,
    output seg_t        digit_seg
);

    logic [SCAN_DIV_BITS-1:0] div_cnt;
    logic                     tick;
    logic [1:0]               pos;
    ctrl_state_t              state_q;
    logic                     state_change;
    logic [6:0]               lead_blank;
    bcd_word_t                shown;
    logic                     upper_used;
    logic                     in_entry;
    logic                     enable;
    bcd_t                     code;

    assign tick         = &div_cnt;
    assign state_change = (state != state_q);

    // scan restarts at position 0 whenever the control state moves
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            pos     <= '0;
            state_q <= IDLE;
        end else begin
            state_q <= state;
            if (state_change) begin
                div_cnt <= '0;
                pos     <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                if (tick) begin
                    pos <= pos + 2'd1;
                end
            end
        end
    end

    // leading zeros blank, digit 0 always shows
    always_comb begin
        lead_blank[6] = (bcd[6] == bcd_t'(0));
        for (int i = 5; i >= 1; i--) begin
            lead_blank[i] = lead_blank[i+1] && (bcd[i] == bcd_t'(0));
        end
        lead_blank[0] = 1'b0;
        for (int i = 0; i < 7; i++) begin
            shown[i] = lead_blank[i] ? CODE_BLANK : bcd[i];
        end
    end

    // digit 3 or above in use means the value needs two pages
    assign upper_used = ~lead_blank[3];

    assign in_entry = (state == INPUT_A) || (state == INPUT_B);
    assign enable   = in_entry || ((state == DISPLAY) && !invalid);

    always_comb begin
        code = CODE_BLANK;
        if (in_entry) begin
            case (pos)
                2'd0:    code = entry.d0;
                2'd1:    code = entry.d1;
                2'd2:    code = entry.d2;
                default: code = entry.sign ? CODE_MINUS : CODE_BLANK;
            endcase
        end else if (state == DISPLAY) begin
            if (page) begin
                code = shown[pos];
            end else if (pos == 2'd3) begin
                code = negative ? CODE_MINUS : CODE_BLANK;
            end else if (upper_used) begin
                code = shown[pos + 3'd4];
            end else begin
                code = shown[pos];
            end
        end
    end

    assign digit_ctrl = enable ? ~(ctrl_t'(1) << pos) : '1;
    assign digit_seg  = SEG_TABLE[code];

endmodule

// ==== calc_top.sv ====
// board top of the calculator; connects buttons and switches to the seven-segment display
module calc_top
    import calc_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 2 ** 16,
    parameter int SCAN_DIV_BITS   = 10
) (
    input  logic       clk,
    input  logic       arst_n,
    input  button_t    board_button,
    input  switch_t    board_switch,
    output ctrl_t      digit_ctrl,
    output seg_t       digit_seg,
    output logic       exe_done,
    output logic [2:0] display_stage
);

    button_t     press;
    ctrl_state_t state;
    logic        entry_clear;
    logic        capture_a;
    logic        capture_b;
    logic        page;
    operand_t    entry;
    logic        result_valid;
    mag_t        magnitude;
    logic        negative;
    logic        invalid;
    bcd_word_t   bcd;
    logic        conv_done;

    button_conditioner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) button_i (
        .clk(clk), .arst_n(arst_n), .board_button(board_button), .press(press)
    );

    calc_control control_i (
        .clk(clk), .arst_n(arst_n), .press(press), .result_valid(result_valid),
        .magnitude(magnitude), .invalid(invalid), .conv_done(conv_done), .state(state),
        .entry_clear(entry_clear), .capture_a(capture_a), .capture_b(capture_b),
        .page(page), .exe_done(exe_done), .display_stage(display_stage)
    );

    operand_entry entry_i (
        .clk(clk), .arst_n(arst_n), .state(state), .entry_clear(entry_clear),
        .press(press), .entry(entry)
    );

    calc_execute execute_i (
        .clk(clk), .arst_n(arst_n), .board_switch(board_switch), .entry(entry),
        .capture_a(capture_a), .capture_b(capture_b), .result_valid(result_valid),
        .magnitude(magnitude), .negative(negative), .invalid(invalid)
    );

    bin_to_bcd convert_i (
        .clk(clk), .arst_n(arst_n), .start(result_valid), .magnitude(magnitude),
        .bcd(bcd), .conv_done(conv_done)
    );

    seven_seg_scan #(
        .SCAN_DIV_BITS(SCAN_DIV_BITS)
    ) scan_i (
        .clk(clk), .arst_n(arst_n), .state(state), .entry(entry), .bcd(bcd),
        .negative(negative), .invalid(invalid), .page(page),
        .digit_ctrl(digit_ctrl), .digit_seg(digit_seg)
    );

endmodule

// ==== tb_calc.sv ====
// self-checking testbench of the calculator top; reads the test vectors and types them in
module tb_calc
    import calc_pkg::*;
();

    localparam int DEBOUNCE     = 4;
    localparam int SCAN_BITS    = 2;
    localparam int HOLD         = DEBOUNCE + 4;
    localparam int PRESS_CYCLES = 2 * HOLD;
    // upper bound of presses per test, scan windows included
    localparam int PRESS_BOUND  = 80;
    localparam int SCAN_WINDOW  = 3 * 4 * (2 ** SCAN_BITS);
    localparam int BLANK        = 10;
    localparam int MINUS        = 11;

    logic       clk;
    logic       arst_n;
    button_t    board_button;
    switch_t    board_switch;
    ctrl_t      digit_ctrl;
    seg_t       digit_seg;
    logic       exe_done;
    logic [2:0] display_stage;

    string       t_name [$];
    int          t_a [$];
    int          t_b [$];
    int          t_res [$];
    switch_t     t_sw [$];
    int          exp_code [4];
    seg_t        seen_seg [4];
    bit          seen_on [4];
    ctrl_t       ctrl_seen;
    int unsigned errors      = 0;
    int unsigned checks      = 0;
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = 32'hFFFF_FFFF;

    calc_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE),
        .SCAN_DIV_BITS(SCAN_BITS)
    ) dut_i (
        .clk(clk), .arst_n(arst_n), .board_button(board_button),
        .board_switch(board_switch), .digit_ctrl(digit_ctrl), .digit_seg(digit_seg),
        .exe_done(exe_done), .display_stage(display_stage)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    // reference segment patterns, active low, dp in bit 0
    function automatic seg_t segments_for(int code);
        case (code)
            0:       return 8'b0000_0011;
            1:       return 8'b1001_1111;
            2:       return 8'b0010_0101;
            3:       return 8'b0000_1101;
            4:       return 8'b1001_1001;
            5:       return 8'b0100_1001;
            6:       return 8'b0100_0001;
            7:       return 8'b0001_1111;
            8:       return 8'b0000_0001;
            9:       return 8'b0001_1001;
            MINUS:   return 8'b1111_1101;
            default: return 8'b1111_1111;
        endcase
    endfunction

    task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_t expected, input ctrl_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_stage(input string name, input logic [2:0] expected,
                               input logic [2:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic read_tests();
        int    fd;
        int    n;
        int    a;
        int    b;
        int    r;
        int    sw;
        string line;
        string name;
        fd = $fopen("calc_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test vector file calc_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %h %d", name, a, b, sw, r);
                    if (n == 5) begin
                        t_name.push_back(name);
                        t_a.push_back(a);
                        t_b.push_back(b);
                        t_sw.push_back(switch_t'(sw));
                        t_res.push_back(r);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic press_button(input int idx);
        @(posedge clk);
        board_button <= button_t'(1 << idx);
        repeat (HOLD) @(posedge clk);
        board_button <= '0;
        repeat (HOLD) @(posedge clk);
    endtask

    // digits in from position 0, cursor ends on the sign
    task automatic enter_operand(input int value);
        int mag;
        mag = (value < 0) ? -value : value;
        repeat (3) press_button(BTN_RIGHT);
        repeat (mag % 10) press_button(BTN_UP);
        press_button(BTN_LEFT);
        repeat ((mag / 10) % 10) press_button(BTN_UP);
        press_button(BTN_LEFT);
        repeat (mag / 100) press_button(BTN_UP);
        press_button(BTN_LEFT);
        if (value < 0) begin
            press_button(BTN_UP);
        end
    endtask

    task automatic set_entry_codes(input int value);
        int mag;
        mag = (value < 0) ? -value : value;
        exp_code[0] = mag % 10;
        exp_code[1] = (mag / 10) % 10;
        exp_code[2] = mag / 100;
        exp_code[3] = (value < 0) ? MINUS : BLANK;
    endtask

    task automatic set_result_codes(input int value, input bit second_page);
        int mag;
        int tmp;
        int msd;
        int shown [7];
        mag = (value < 0) ? -value : value;
        tmp = mag;
        msd = 0;
        for (int i = 0; i < 7; i++) begin
            shown[i] = tmp % 10;
            if (shown[i] != 0) msd = i;
            tmp = tmp / 10;
        end
        // zeros above the top nonzero digit go dark
        for (int i = 1; i < 7; i++) begin
            if (i > msd) shown[i] = BLANK;
        end
        if (second_page) begin
            for (int p = 0; p < 4; p++) exp_code[p] = shown[p];
        end else begin
            exp_code[3] = (value < 0) ? MINUS : BLANK;
            for (int p = 0; p < 3; p++) exp_code[p] = (mag >= 1000) ? shown[p + 4] : shown[p];
        end
    endtask

    // watch the display for a few full scans
    task automatic capture_scan();
        int pos;
        for (int p = 0; p < 4; p++) begin
            seen_on[p]  = 1'b0;
            seen_seg[p] = '1;
        end
        ctrl_seen = '1;
        repeat (SCAN_WINDOW) begin
            @(negedge clk);
            ctrl_seen = ctrl_seen & digit_ctrl;
            case (digit_ctrl)
                4'b1110: pos = 0;
                4'b1101: pos = 1;
                4'b1011: pos = 2;
                4'b0111: pos = 3;
                4'b1111: pos = -1;
                default: pos = -2;
            endcase
            if (pos == -2) begin
                errors++;
                $display("digit enables %b have more than one digit on", digit_ctrl);
            end else if (pos >= 0) begin
                seen_on[pos]  = 1'b1;
                seen_seg[pos] = digit_seg;
            end
        end
    endtask

    task automatic expect_display(input string name);
        capture_scan();
        for (int p = 0; p < 4; p++) begin
            if (!seen_on[p]) begin
                errors++;
                $display("%s: display position %0d was never switched on", name, p);
            end else begin
                check_seg($sformatf("%s pos%0d", name, p), segments_for(exp_code[p]),
                          seen_seg[p]);
            end
        end
    endtask

    task automatic run_test(input int i);
        string   name;
        int      r;
        bit      bad_op;
        name   = t_name[i];
        r      = t_res[i];
        // no add, sub or mul switch up means nothing to compute
        bad_op = (t_sw[i][2:0] == 3'b000);
        @(posedge clk);
        board_switch <= t_sw[i];
        enter_operand(t_a[i]);
        set_entry_codes(t_a[i]);
        expect_display({name, " entry a"});
        press_button(BTN_MID);
        enter_operand(t_b[i]);
        set_entry_codes(t_b[i]);
        expect_display({name, " entry b"});
        press_button(BTN_MID);
        @(negedge clk);
        while (exe_done !== 1'b1) @(negedge clk);
        check_stage({name, " stage"}, 3'd1, display_stage);
        if (bad_op) begin
            capture_scan();
            check_ctrl({name, " blanked"}, 4'b1111, ctrl_seen);
            press_button(BTN_MID);
        end else begin
            set_result_codes(r, 1'b0);
            expect_display({name, " page 0"});
            press_button(BTN_MID);
            if (r >= 1000 || r <= -1000) begin
                @(negedge clk);
                check_flag({name, " still done"}, 1'b1, exe_done);
                check_stage({name, " stage"}, 3'd2, display_stage);
                set_result_codes(r, 1'b1);
                expect_display({name, " page 1"});
                press_button(BTN_MID);
            end
        end
        @(negedge clk);
        check_flag({name, " back to entry"}, 1'b0, exe_done);
        check_stage({name, " stage after"}, 3'd1, display_stage);
        set_entry_codes(0);
        expect_display({name, " cleared entry"});
    endtask

    initial begin
        arst_n       = 1'b0;
        board_button = '0;
        board_switch = '0;
        read_tests();
        cycle_limit = (t_name.size() + 1) * PRESS_BOUND * PRESS_CYCLES * 2;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag("reset exe_done", 1'b0, exe_done);
        check_stage("reset stage", 3'd1, display_stage);
        check_ctrl("reset digits off", 4'b1111, digit_ctrl);
        repeat (7) @(posedge clk);
        arst_n <= 1'b1;
        if (t_name.size() == 0) begin
            errors++;
            $display("no test vectors were loaded");
        end else begin
            repeat (2) @(posedge clk);
            set_entry_codes(0);
            expect_display("idle entry");
            // digit wraps at both ends
            press_button(BTN_DOWN);
            set_entry_codes(9);
            expect_display("down from 0");
            press_button(BTN_UP);
            set_entry_codes(0);
            expect_display("up from 9");
            foreach (t_name[i]) begin
                run_test(i);
            end
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== calc_tests.txt ====
# name  operand_a  operand_b  switch_word_hex  expected_result
# operands are signed three-digit decimals, the result is signed decimal
add_pos       123   456  0001     579
add_mix      -250    75  0001    -175
add_neg      -608  -391  0001    -999
sub_mix        42  -317  0002     359
sub_neg        15   600  0002    -585
sub_zero       -7    -7  0002       0
mul_small      12   -11  0004    -132
mul_zero        0  -123  0004       0
mul_4dig      -25   -48  0004    1200
mul_big       999  -999  0004 -998001
mul_pos       321   654  0004  209934
add_max       999   999  0001    1998
prio_add_mul  300   250  0005     550
prio_sub_mul  -20    30  0006     -50
inv_none        5     5  0000       0
inv_high        5     5  0008       0
inv_high_mix   17    -3  4010       0

// ==== list.f ====
calc_pkg.sv
button_conditioner.sv
operand_entry.sv
calc_control.sv
calc_execute.sv
bin_to_bcd.sv
seven_seg_scan.sv
calc_top.sv
tb_calc.sv

// ==== Bender.yml ====
package:
  name: calc

sources:
  - calc_pkg.sv
  - button_conditioner.sv
  - operand_entry.sv
  - calc_control.sv
  - calc_execute.sv
  - bin_to_bcd.sv
  - seven_seg_scan.sv
  - calc_top.sv
  - target: test
    files:
      - tb_calc.sv
